// ==== source/spi_frame_pkg.sv ====
package spi_frame_pkg;

    // ============================================================
    // frame layout
    // ============================================================
    localparam int FRM_W  = 24;
    localparam int CMD_W  = 8;
    localparam int DATA_W = 8;
    localparam int CRC_W  = 8;
    localparam int CHK_W  = CMD_W + DATA_W;

    // miso pointer spans response plus received bits
    localparam int MISO_PTR_W = $clog2(2 * FRM_W);

    // crc-8, msb first over the upper 16 bits
    localparam logic [CRC_W-1:0] CRC_POLY = 8'h07;
    localparam logic [CRC_W-1:0] CRC_INIT = 8'h00;

    // request as seen on mosi
    typedef struct packed {
        logic              wr;
        logic [CMD_W-2:0]  addr;
        logic [DATA_W-1:0] data;
        logic [CRC_W-1:0]  crc;
    } spi_req_t;

    // response as shifted out on miso
    typedef struct packed {
        logic              is_wr_ack;
        logic [CMD_W-2:0]  addr;
        logic [DATA_W-1:0] data;
        logic [CRC_W-1:0]  crc;
    } spi_rsp_t;

    typedef union packed {
        spi_req_t req;
        spi_rsp_t rsp;
    } spi_frame_t;

endpackage

// ==== source/reg_map_pkg.sv ====
package reg_map_pkg;

    // ============================================================
    // register bank geometry
    // ============================================================
    localparam int REG_AW  = 7;
    localparam int REG_DW  = 8;
    localparam int REG_NUM = 128;

    // every register comes out of reset cleared
    localparam logic [REG_DW-1:0] REG_RST_VAL = 8'h00;

endpackage

// ==== source/gnrl_sync.sv ====
module gnrl_sync #(
    parameter int            DW      = 1,
    parameter logic [DW-1:0] DEF_VAL = '0
) (
    input  logic [DW-1:0] i_data,
    output logic [DW-1:0] o_data,
    input  logic          i_clk,
    input  logic          i_rst_n
);

    logic [DW-1:0] sync_ff1;

    // two stages into the i_clk domain
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_ff1 <= DEF_VAL;
            o_data   <= DEF_VAL;
        end else begin
            sync_ff1 <= i_data;
            o_data   <= sync_ff1;
        end
    end

endmodule

// ==== source/crc16to8_parallel.sv ====
module crc16to8_parallel (
    input  logic [spi_frame_pkg::CHK_W-1:0] i_data,
    output logic [spi_frame_pkg::CRC_W-1:0] o_crc
);

    logic [spi_frame_pkg::CRC_W-1:0] crc_acc;
    logic                            fb;

    // bit-serial lfsr unrolled over the whole word, msb first
    always_comb begin
        crc_acc = spi_frame_pkg::CRC_INIT;
        fb      = 1'b0;
        for (int i = spi_frame_pkg::CHK_W - 1; i >= 0; i--) begin
            fb      = crc_acc[spi_frame_pkg::CRC_W-1] ^ i_data[i];
            crc_acc = {crc_acc[spi_frame_pkg::CRC_W-2:0], 1'b0};
            if (fb) begin
                crc_acc = crc_acc ^ spi_frame_pkg::CRC_POLY;
            end
        end
    end

    assign o_crc = crc_acc;

endmodule

// ==== source/spi_slv.sv ====
module spi_slv (
    input  logic                           i_spi_sclk,
    input  logic                           i_spi_csb,
    input  logic                           i_spi_mosi,
    output logic                           o_spi_miso,
    input  logic                           i_spi_slv_en,
    output logic                           o_spi_rac_wr_req,
    output logic                           o_spi_rac_rd_req,
    output logic [reg_map_pkg::REG_AW-1:0] o_spi_rac_addr,
    output logic [reg_map_pkg::REG_DW-1:0] o_spi_rac_wdata,
    input  logic                           i_rac_spi_wack,
    input  logic                           i_rac_spi_rack,
    input  logic [reg_map_pkg::REG_AW-1:0] i_rac_spi_addr,
    input  logic [reg_map_pkg::REG_DW-1:0] i_rac_spi_data,
    output logic                           o_spi_err,
    input  logic                           i_clk,
    input  logic                           i_rst_n
);

    logic [spi_frame_pkg::FRM_W-1:0]      rx_bits;
    spi_frame_pkg::spi_frame_t            rx_frm;
    spi_frame_pkg::spi_frame_t            rsp_frm;
    spi_frame_pkg::spi_frame_t            rsp_next;
    logic [2*spi_frame_pkg::FRM_W-1:0]    miso_cache;
    logic [spi_frame_pkg::MISO_PTR_W-1:0] miso_rptr;
    logic                                 csb_sync;
    logic                                 csb_sync_d;
    logic                                 csb_rise;
    logic                                 csb_fall;
    logic                                 launch;
    logic [spi_frame_pkg::CHK_W-1:0]      crc_in;
    logic [spi_frame_pkg::CRC_W-1:0]      crc_out;
    logic                                 crc_err;
    logic                                 gap_err;
    logic                                 gap_blk;
    logic                                 acc_pend;
    logic                                 rac_ack;
    logic [2:0]                           ack_dly;
    logic                                 req_wen;
    logic                                 req_ren;

    // ============================================================
    // sclk domain
    // ============================================================
    always_ff @(posedge i_spi_sclk) begin
        rx_bits <= {rx_bits[spi_frame_pkg::FRM_W-2:0], i_spi_mosi};
    end

    // walks down the response, then parks on the oldest received bit
    always_ff @(negedge i_spi_sclk or posedge i_spi_csb) begin
        if (i_spi_csb) begin
            miso_rptr <= spi_frame_pkg::MISO_PTR_W'(2 * spi_frame_pkg::FRM_W - 1);
        end else if (miso_rptr != spi_frame_pkg::MISO_PTR_W'(spi_frame_pkg::FRM_W - 1)) begin
            miso_rptr <= miso_rptr - 1'b1;
        end
    end

    assign miso_cache = {rsp_frm, rx_bits};
    assign o_spi_miso = miso_cache[miso_rptr];

    // ============================================================
    // chip select into i_clk
    // ============================================================
    gnrl_sync #(
        .DW      (1),
        .DEF_VAL (1'b1)
    ) u_csb_sync (
        .i_data  (i_spi_csb),
        .o_data  (csb_sync),
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            csb_sync_d <= 1'b1;
            csb_rise   <= 1'b0;
            csb_fall   <= 1'b0;
        end else begin
            csb_sync_d <= csb_sync;
            csb_rise   <= csb_sync & ~csb_sync_d;
            csb_fall   <= ~csb_sync & csb_sync_d;
        end
    end

    assign rx_frm  = rx_bits;
    assign launch  = csb_rise & i_spi_slv_en;
    assign rac_ack = i_rac_spi_wack | i_rac_spi_rack;

    // one crc unit, shared between frame check and response signing
    assign crc_in = rac_ack ? {i_rac_spi_wack, i_rac_spi_addr, i_rac_spi_data}
                            : {rx_frm.req.wr, rx_frm.req.addr, rx_frm.req.data};

    crc16to8_parallel u_crc (
        .i_data (crc_in),
        .o_crc  (crc_out)
    );

    assign crc_err = launch & (crc_out != rx_frm.req.crc);

    // ============================================================
    // access gap tracking
    // ============================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ack_dly  <= 3'b000;
            acc_pend <= 1'b0;
            gap_blk  <= 1'b0;
        end else begin
            ack_dly <= {ack_dly[1:0], rac_ack};
            // hold off three cycles so sclk sees the new response
            if (ack_dly[2]) begin
                acc_pend <= 1'b0;
            end else if (req_wen | req_ren) begin
                acc_pend <= 1'b1;
            end
            if (launch) begin
                gap_blk <= 1'b0;
            end else if (gap_err) begin
                gap_blk <= 1'b1;
            end
        end
    end

    assign gap_err = csb_fall & i_spi_slv_en & acc_pend;
    assign req_wen = launch & rx_frm.req.wr & ~crc_err & ~gap_blk;
    assign req_ren = launch & ~rx_frm.req.wr & ~crc_err & ~gap_blk;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_spi_err        <= 1'b0;
            o_spi_rac_wr_req <= 1'b0;
            o_spi_rac_rd_req <= 1'b0;
        end else begin
            o_spi_err        <= crc_err | gap_err;
            o_spi_rac_wr_req <= i_rac_spi_wack ? 1'b0 : (req_wen | o_spi_rac_wr_req);
            o_spi_rac_rd_req <= i_rac_spi_rack ? 1'b0 : (req_ren | o_spi_rac_rd_req);
        end
    end

    always_ff @(posedge i_clk) begin
        if (req_wen | req_ren) begin
            o_spi_rac_addr  <= rx_frm.req.addr;
            o_spi_rac_wdata <= rx_frm.req.data;
        end
    end

    // ============================================================
    // response frame
    // ============================================================
    always_comb begin
        rsp_next.rsp.is_wr_ack = i_rac_spi_wack;
        rsp_next.rsp.addr      = i_rac_spi_addr;
        rsp_next.rsp.data      = i_rac_spi_data;
        rsp_next.rsp.crc       = crc_out;
    end

    // crc of an all-zero header is zero
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rsp_frm <= '0;
        end else if (rac_ack) begin
            rsp_frm <= rsp_next;
        end
    end

endmodule

// ==== source/reg_access_ctrl.sv ====
module reg_access_ctrl (
    input  logic                           i_spi_rac_wr_req,
    input  logic                           i_spi_rac_rd_req,
    input  logic [reg_map_pkg::REG_AW-1:0] i_spi_rac_addr,
    input  logic [reg_map_pkg::REG_DW-1:0] i_spi_rac_wdata,
    output logic                           o_rac_spi_wack,
    output logic                           o_rac_spi_rack,
    output logic [reg_map_pkg::REG_AW-1:0] o_rac_spi_addr,
    output logic [reg_map_pkg::REG_DW-1:0] o_rac_spi_data,
    input  logic [reg_map_pkg::REG_AW-1:0] i_paddr,
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [reg_map_pkg::REG_DW-1:0] i_pwdata,
    output logic [reg_map_pkg::REG_DW-1:0] o_prdata,
    output logic                           o_pready,
    output logic                           o_bank_psel,
    output logic                           o_bank_penable,
    output logic                           o_bank_pwrite,
    output logic [reg_map_pkg::REG_AW-1:0] o_bank_paddr,
    output logic [reg_map_pkg::REG_DW-1:0] o_bank_pwdata,
    input  logic [reg_map_pkg::REG_DW-1:0] i_bank_prdata,
    input  logic                           i_bank_pready,
    input  logic                           i_clk,
    input  logic                           i_rst_n
);

    logic bus_sel;
    logic bus_en;
    logic own_spi;
    logic spi_req;
    logic host_req;
    logic xfer_done;

    assign spi_req   = i_spi_rac_wr_req | i_spi_rac_rd_req;
    // host is waiting in setup or access phase
    assign host_req  = i_psel;
    assign xfer_done = bus_sel & bus_en & i_bank_pready;

    // ============================================================
    // idle / setup / access, coded as {psel, penable}
    // ============================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bus_sel <= 1'b0;
            bus_en  <= 1'b0;
            own_spi <= 1'b0;
        end else if (!bus_sel) begin
            // spi wins a tie
            if (spi_req) begin
                bus_sel <= 1'b1;
                own_spi <= 1'b1;
            end else if (host_req) begin
                bus_sel <= 1'b1;
                own_spi <= 1'b0;
            end
        end else if (!bus_en) begin
            bus_en <= 1'b1;
        end else if (i_bank_pready) begin
            bus_sel <= 1'b0;
            bus_en  <= 1'b0;
        end
    end

    // bank link follows the owner
    assign o_bank_psel    = bus_sel;
    assign o_bank_penable = bus_en;
    assign o_bank_pwrite  = own_spi ? i_spi_rac_wr_req : i_pwrite;
    assign o_bank_paddr   = own_spi ? i_spi_rac_addr : i_paddr;
    assign o_bank_pwdata  = own_spi ? i_spi_rac_wdata : i_pwdata;

    // spi completion, echo write data or return read data
    assign o_rac_spi_wack = xfer_done & own_spi & i_spi_rac_wr_req;
    assign o_rac_spi_rack = xfer_done & own_spi & i_spi_rac_rd_req;
    assign o_rac_spi_addr = i_spi_rac_addr;
    assign o_rac_spi_data = i_spi_rac_wr_req ? i_spi_rac_wdata : i_bank_prdata;

    // host completion
    assign o_pready = xfer_done & ~own_spi;
    assign o_prdata = i_bank_prdata;

endmodule

// ==== source/reg_bank.sv ====
module reg_bank (
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [reg_map_pkg::REG_AW-1:0] i_paddr,
    input  logic [reg_map_pkg::REG_DW-1:0] i_pwdata,
    output logic [reg_map_pkg::REG_DW-1:0] o_prdata,
    output logic                           o_pready,
    input  logic                           i_clk,
    input  logic                           i_rst_n
);

    logic [reg_map_pkg::REG_DW-1:0] regs [reg_map_pkg::REG_NUM];
    logic                           acc_start;

    // first access cycle, pready follows one cycle later
    assign acc_start = i_psel & i_penable & ~o_pready;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pready <= 1'b0;
            for (int i = 0; i < reg_map_pkg::REG_NUM; i++) begin
                regs[i] <= reg_map_pkg::REG_RST_VAL;
            end
        end else begin
            o_pready <= acc_start;
            if (acc_start & i_pwrite) begin
                regs[i_paddr] <= i_pwdata;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (acc_start & ~i_pwrite) begin
            o_prdata <= regs[i_paddr];
        end
    end

endmodule

// ==== source/spi_reg_bridge.sv ====
module spi_reg_bridge (
    input  logic                           i_spi_sclk,
    input  logic                           i_spi_csb,
    input  logic                           i_spi_mosi,
    output logic                           o_spi_miso,
    input  logic                           i_spi_slv_en,
    output logic                           o_spi_err,
    input  logic [reg_map_pkg::REG_AW-1:0] i_paddr,
    input  logic                           i_psel,
    input  logic                           i_penable,
    input  logic                           i_pwrite,
    input  logic [reg_map_pkg::REG_DW-1:0] i_pwdata,
    output logic [reg_map_pkg::REG_DW-1:0] o_prdata,
    output logic                           o_pready,
    input  logic                           i_clk,
    input  logic                           i_rst_n
);

    // slave to controller
    logic                           spi_rac_wr_req;
    logic                           spi_rac_rd_req;
    logic [reg_map_pkg::REG_AW-1:0] spi_rac_addr;
    logic [reg_map_pkg::REG_DW-1:0] spi_rac_wdata;
    logic                           rac_spi_wack;
    logic                           rac_spi_rack;
    logic [reg_map_pkg::REG_AW-1:0] rac_spi_addr;
    logic [reg_map_pkg::REG_DW-1:0] rac_spi_data;

    // internal apb to the bank
    logic                           bank_psel;
    logic                           bank_penable;
    logic                           bank_pwrite;
    logic [reg_map_pkg::REG_AW-1:0] bank_paddr;
    logic [reg_map_pkg::REG_DW-1:0] bank_pwdata;
    logic [reg_map_pkg::REG_DW-1:0] bank_prdata;
    logic                           bank_pready;

    spi_slv u_spi_slv (
        .i_spi_sclk       (i_spi_sclk),
        .i_spi_csb        (i_spi_csb),
        .i_spi_mosi       (i_spi_mosi),
        .o_spi_miso       (o_spi_miso),
        .i_spi_slv_en     (i_spi_slv_en),
        .o_spi_rac_wr_req (spi_rac_wr_req),
        .o_spi_rac_rd_req (spi_rac_rd_req),
        .o_spi_rac_addr   (spi_rac_addr),
        .o_spi_rac_wdata  (spi_rac_wdata),
        .i_rac_spi_wack   (rac_spi_wack),
        .i_rac_spi_rack   (rac_spi_rack),
        .i_rac_spi_addr   (rac_spi_addr),
        .i_rac_spi_data   (rac_spi_data),
        .o_spi_err        (o_spi_err),
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n)
    );

    reg_access_ctrl u_rac (
        .i_spi_rac_wr_req (spi_rac_wr_req),
        .i_spi_rac_rd_req (spi_rac_rd_req),
        .i_spi_rac_addr   (spi_rac_addr),
        .i_spi_rac_wdata  (spi_rac_wdata),
        .o_rac_spi_wack   (rac_spi_wack),
        .o_rac_spi_rack   (rac_spi_rack),
        .o_rac_spi_addr   (rac_spi_addr),
        .o_rac_spi_data   (rac_spi_data),
        .i_paddr          (i_paddr),
        .i_psel           (i_psel),
        .i_penable        (i_penable),
        .i_pwrite         (i_pwrite),
        .i_pwdata         (i_pwdata),
        .o_prdata         (o_prdata),
        .o_pready         (o_pready),
        .o_bank_psel      (bank_psel),
        .o_bank_penable   (bank_penable),
        .o_bank_pwrite    (bank_pwrite),
        .o_bank_paddr     (bank_paddr),
        .o_bank_pwdata    (bank_pwdata),
        .i_bank_prdata    (bank_prdata),
        .i_bank_pready    (bank_pready),
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n)
    );

    reg_bank u_reg_bank (
        .i_psel    (bank_psel),
        .i_penable (bank_penable),
        .i_pwrite  (bank_pwrite),
        .i_paddr   (bank_paddr),
        .i_pwdata  (bank_pwdata),
        .o_prdata  (bank_prdata),
        .o_pready  (bank_pready),
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n)
    );

endmodule

// ==== verification/tb_spi_reg_bridge.sv ====
module tb_spi_reg_bridge;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYC = 200;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_spi_sclk;
    logic       i_spi_csb;
    logic       i_spi_mosi;
    logic       o_spi_miso;
    logic       i_spi_slv_en;
    logic       o_spi_err;
    logic [6:0] i_paddr;
    logic       i_psel;
    logic       i_penable;
    logic       i_pwrite;
    logic [7:0] i_pwdata;
    logic [7:0] o_prdata;
    logic       o_pready;

    // reference model state
    logic [7:0]  model_mem [128];
    logic [23:0] model_rsp;

    int    err_pulses;
    int    ack_pulses;
    string test_name;
    int    test_errs;
    int    total_errs;
    int    tests_run;
    int    tests_failed;

    spi_reg_bridge dut0 (
        .i_spi_sclk   (i_spi_sclk),
        .i_spi_csb    (i_spi_csb),
        .i_spi_mosi   (i_spi_mosi),
        .o_spi_miso   (o_spi_miso),
        .i_spi_slv_en (i_spi_slv_en),
        .o_spi_err    (o_spi_err),
        .i_paddr      (i_paddr),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n)
    );

    always #10 i_clk = ~i_clk;

    // count error pulses and spi acks mid-cycle
    always @(negedge i_clk) begin
        if (o_spi_err === 1'b1) begin
            err_pulses++;
        end
        if ((dut0.rac_spi_wack | dut0.rac_spi_rack) === 1'b1) begin
            ack_pulses++;
        end
    end

    // ============================================================
    // model helpers
    // ============================================================
    // crc-8 poly 0x07, processed a byte at a time
    function automatic logic [7:0] model_crc(input logic [15:0] hdr);
        logic [7:0] c;
        c = 8'h00;
        for (int b = 1; b >= 0; b--) begin
            c = c ^ hdr[b*8 +: 8];
            for (int k = 0; k < 8; k++) begin
                c = c[7] ? ((c << 1) ^ 8'h07) : (c << 1);
            end
        end
        return c;
    endfunction

    // same layout for request and response words
    function automatic logic [23:0] build_word(input logic flag, input logic [6:0] addr,
                                               input logic [7:0] data);
        return {flag, addr, data, model_crc({flag, addr, data})};
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Error: %s %s expected %0h actual %0h", test_name, what, exp, act);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errs);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge i_clk);
        #2;
    endtask

    // ============================================================
    // spi and apb drivers
    // ============================================================
    // mosi set while sclk low, miso taken just before each rising edge
    task automatic spi_shift_frame(input logic [23:0] tx, output logic [23:0] rx);
        i_spi_csb = 1'b0;
        for (int i = 23; i >= 0; i--) begin
            i_spi_mosi = tx[i];
            #80;
            rx[i] = o_spi_miso;
            i_spi_sclk = 1'b1;
            #80;
            i_spi_sclk = 1'b0;
        end
        #80;
        i_spi_csb = 1'b1;
    endtask

    task automatic wait_spi_ack(output logic acked);
        int n;
        acked = 1'b0;
        n = 0;
        while (!acked && n < TIMEOUT_CYC) begin
            @(negedge i_clk);
            acked = dut0.rac_spi_wack | dut0.rac_spi_rack;
            n++;
        end
        @(posedge i_clk);
        #2;
        if (!acked) begin
            $display("Timeout: no SPI acknowledge within %0d cycles in test %s",
                     TIMEOUT_CYC, test_name);
            test_errs++;
        end
    endtask

    task automatic wait_spi_err();
        int   n;
        logic seen;
        seen = 1'b0;
        n = 0;
        while (!seen && n < TIMEOUT_CYC) begin
            @(negedge i_clk);
            seen = o_spi_err;
            n++;
        end
        @(posedge i_clk);
        #2;
        if (!seen) begin
            $display("Timeout: the SPI error pulse never came in test %s", test_name);
            test_errs++;
        end
    endtask

    // one frame, check of the previous response, then the access itself
    task automatic spi_access(input logic wr, input logic [6:0] addr, input logic [7:0] data);
        logic [23:0] rx;
        logic        acked;
        spi_shift_frame(build_word(wr, addr, data), rx);
        if (rx !== model_rsp) begin
            report_mismatch("miso response", model_rsp, rx);
        end
        wait_spi_ack(acked);
        if (acked) begin
            if (wr) begin
                model_mem[addr] = data;
            end
            model_rsp = build_word(wr, addr, model_mem[addr]);
        end
        // leave room for the pending flag to clear
        idle_cycles(6);
    endtask

    task automatic host_access(input logic wr, input logic [6:0] addr, input logic [7:0] wdata);
        int         n;
        logic       done;
        logic [7:0] rd;
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = wr;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(posedge i_clk);
        #2;
        i_penable = 1'b1;
        done = 1'b0;
        rd = 8'h00;
        n = 0;
        while (!done && n < TIMEOUT_CYC) begin
            @(negedge i_clk);
            if (o_pready) begin
                done = 1'b1;
                rd = o_prdata;
            end
            n++;
        end
        @(posedge i_clk);
        #2;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        if (!done) begin
            $display("Timeout: host APB transfer got no pready in test %s", test_name);
            test_errs++;
        end else if (wr) begin
            model_mem[addr] = wdata;
        end else if (rd !== model_mem[addr]) begin
            report_mismatch("host read", model_mem[addr], rd);
        end
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        logic [6:0]  a;
        logic [6:0]  ha;
        logic [7:0]  d;
        logic [7:0]  hd;
        logic        hwr;
        logic [23:0] rx;
        int          kind;
        int          hdly;
        int          e0;
        int          k0;

        i_clk        = 1'b0;
        i_rst_n      = 1'b0;
        i_spi_sclk   = 1'b0;
        i_spi_csb    = 1'b1;
        i_spi_mosi   = 1'b0;
        i_spi_slv_en = 1'b1;
        i_paddr      = 7'h00;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_pwdata     = 8'h00;
        void'($urandom(32'h4152a2b0));

        err_pulses   = 0;
        ack_pulses   = 0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 128; i++) begin
            model_mem[i] = 8'h00;
        end
        model_rsp = build_word(1'b0, 7'h00, 8'h00);

        repeat (8) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        idle_cycles(4);

        start_test("spi_write_read");
        spi_access(1'b1, 7'h15, 8'hc3);
        spi_access(1'b0, 7'h15, 8'h00);
        spi_access(1'b0, 7'h15, 8'h00);
        finish_test();

        start_test("crc_error");
        e0 = err_pulses;
        spi_shift_frame(build_word(1'b1, 7'h2a, 8'h99) ^ 24'h00005a, rx);
        if (rx !== model_rsp) begin
            report_mismatch("miso response", model_rsp, rx);
        end
        wait_spi_err();
        idle_cycles(6);
        if (err_pulses != e0 + 1) begin
            report_mismatch("error pulses", e0 + 1, err_pulses);
        end
        spi_access(1'b0, 7'h2a, 8'h00);
        spi_access(1'b0, 7'h2a, 8'h00);
        finish_test();

        start_test("host_apb");
        host_access(1'b1, 7'h40, 8'h5e);
        host_access(1'b0, 7'h40, 8'h00);
        spi_access(1'b0, 7'h40, 8'h00);
        spi_access(1'b1, 7'h41, 8'ha7);
        host_access(1'b0, 7'h41, 8'h00);
        finish_test();

        // second frame starts one clock after the first ends
        start_test("access_gap");
        e0 = err_pulses;
        k0 = ack_pulses;
        spi_shift_frame(build_word(1'b1, 7'h10, 8'h3c), rx);
        if (rx !== model_rsp) begin
            report_mismatch("miso response", model_rsp, rx);
        end
        #20;
        spi_shift_frame(build_word(1'b1, 7'h11, 8'hd2), rx);
        idle_cycles(10);
        if (err_pulses != e0 + 1) begin
            report_mismatch("error pulses", e0 + 1, err_pulses);
        end
        if (ack_pulses != k0 + 1) begin
            report_mismatch("spi acks", k0 + 1, ack_pulses);
        end
        model_mem[7'h10] = 8'h3c;
        model_rsp = build_word(1'b1, 7'h10, 8'h3c);
        host_access(1'b0, 7'h10, 8'h00);
        host_access(1'b0, 7'h11, 8'h00);
        finish_test();

        start_test("slave_disabled");
        e0 = err_pulses;
        k0 = ack_pulses;
        i_spi_slv_en = 1'b0;
        spi_shift_frame(build_word(1'b1, 7'h22, 8'h77), rx);
        if (rx !== model_rsp) begin
            report_mismatch("miso response", model_rsp, rx);
        end
        idle_cycles(12);
        if (err_pulses != e0) begin
            report_mismatch("error pulses", e0, err_pulses);
        end
        if (ack_pulses != k0) begin
            report_mismatch("spi acks", k0, ack_pulses);
        end
        i_spi_slv_en = 1'b1;
        host_access(1'b0, 7'h22, 8'h00);
        finish_test();

        // host side runs beside the frame, on another address
        start_test("random_mix");
        for (int i = 0; i < 60; i++) begin
            kind = $urandom_range(3);
            a = 7'($urandom);
            d = 8'($urandom);
            if (kind < 2) begin
                ha = 7'($urandom);
                if (ha == a) begin
                    ha = ha ^ 7'h01;
                end
                hd   = 8'($urandom);
                hwr  = 1'($urandom);
                hdly = $urandom_range(215, 1);
                fork
                    spi_access(kind == 0, a, d);
                    begin
                        idle_cycles(hdly);
                        host_access(hwr, ha, hd);
                    end
                join
            end else begin
                host_access(kind == 2, a, d);
            end
        end
        spi_access(1'b0, 7'h00, 8'h00);
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== spi_reg_bridge.f ====
source/spi_frame_pkg.sv
source/reg_map_pkg.sv
source/gnrl_sync.sv
source/crc16to8_parallel.sv
source/spi_slv.sv
source/reg_access_ctrl.sv
source/reg_bank.sv
source/spi_reg_bridge.sv
verification/tb_spi_reg_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_spi_reg_bridge \
    -f spi_reg_bridge.f \
    -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "Testbench passed"; then
    exit 0
fi
exit 1
